// ==== build.f ====
+incdir+verilog
verilog/rv32_pkg.sv
verilog/decode_if.sv
verilog/instr_capture.sv
verilog/control_unit.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/result_stage.sv
verilog/rv32_exec_top.sv
tb/rv32_exec_asserts.sv
tb/rv32_exec_tb.sv

// ==== tb/rv32_exec_tb.sv ====
// Random RV32I instruction stream against a model register file.
// Each strobe is expected as one result record two cycles later.
// Registers x0..x7 only, so operands depend on recent results.
`timescale 1ns/10ps
`include "rv32_macros.svh"
`default_nettype none

module rv32_exec_tb;
  import rv32_pkg::*;

  typedef struct packed {
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     mem_valid;
    logic     mem_we;
    word_t    mem_addr;
    word_t    mem_wdata;
    logic     redirect;
    word_t    target;
    trap_t    trap;
  } rec_t;

  logic     CLK = 1'b0;
  logic     rst_i;
  logic     instr_valid_i;
  instr_t   instr_i;
  word_t    pc_i;
  logic     wb_valid_o;
  reg_idx_t wb_rd_o;
  word_t    wb_data_o;
  logic     mem_valid_o;
  logic     mem_we_o;
  word_t    mem_addr_o;
  word_t    mem_wdata_o;
  logic     redirect_o;
  word_t    target_o;
  trap_t    trap_o;

  logic [31:0] seed = 32'h79a3;
  word_t       model_regs [32];
  rec_t        exp_q [$];
  string       name_q [$];

  rv32_exec_top UUT (.*);

  always #50 CLK = ~CLK;

  function automatic logic [31:0] xorshift32();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  // RV32I integer semantics by funct3 with alt as instruction bit 30
  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_trap(input string name, input trap_t exp, input trap_t act);
    if (act !== exp) stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) stop_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
  endtask

  // Payloads only matter while their valid bit is high
  task automatic check_record(input rec_t e, input string name);
    check_trap({name, " trap_o"}, e.trap, trap_o);
    check_flag({name, " wb_valid_o"}, e.wb_valid, wb_valid_o);
    check_flag({name, " mem_valid_o"}, e.mem_valid, mem_valid_o);
    check_flag({name, " redirect_o"}, e.redirect, redirect_o);
    if (e.wb_valid) begin
      check_idx({name, " wb_rd_o"}, e.wb_rd, wb_rd_o);
      check_word({name, " wb_data_o"}, e.wb_data, wb_data_o);
    end
    if (e.mem_valid) begin
      check_flag({name, " mem_we_o"}, e.mem_we, mem_we_o);
      check_word({name, " mem_addr_o"}, e.mem_addr, mem_addr_o);
      if (e.mem_we) check_word({name, " mem_wdata_o"}, e.mem_wdata, mem_wdata_o);
    end
    if (e.redirect) check_word({name, " target_o"}, e.target, target_o);
  endtask

  task automatic push_idle(input string name);
    instr_valid_i = 1'b0;
    instr_i       = `RV32_NOP;
    exp_q.push_back('0);
    name_q.push_back(name);
  endtask

  task automatic issue_random();
    logic [31:0] r;
    logic [31:0] u;
    logic [2:0]  f3;
    logic        alt;
    logic        wen;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       imm;
    word_t       pc;
    word_t       res;
    instr_t      ins;
    rec_t        e;
    string       name;
    r    = xorshift32();
    u    = xorshift32();
    pc   = xorshift32() & ~32'h3;
    f3   = r[10:8];
    rd   = reg_idx_t'(r[2:0]);
    rs1  = reg_idx_t'(r[5:3]);
    rs2  = reg_idx_t'(r[13:11]);
    imm  = {{20{u[11]}}, u[11:0]};
    e    = '0;
    wen  = 1'b0;
    res  = '0;
    case (r[31:16] % 14)
      0, 1, 2, 3: begin
        alt  = u[30] && (f3 == 3'd0 || f3 == 3'd5);
        ins  = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'h33};
        res  = alu_model(f3, alt, model_regs[rs1], model_regs[rs2]);
        wen  = 1'b1;
        name = "REGREG";
      end
      4, 5: begin
        alt  = u[30] && (f3 == 3'd5);
        ins  = {imm[11:0], rs1, f3, rd, 7'h13};
        res  = alu_model(f3, 1'b0, model_regs[rs1], imm);
        // Shifts carry shamt in the low immediate bits
        if (f3 == 3'd1 || f3 == 3'd5) begin
          ins = {1'b0, alt, 5'd0, u[24:20], rs1, f3, rd, 7'h13};
          res = alu_model(f3, alt, model_regs[rs1], word_t'(u[24:20]));
        end
        wen  = 1'b1;
        name = "IMMED";
      end
      6, 7: begin
        ins  = {u[31:12], rd, r[16] ? 7'h17 : 7'h37};
        res  = {u[31:12], 12'd0} + (r[16] ? pc : 32'd0);
        wen  = 1'b1;
        name = r[16] ? "AUIPC" : "LUI";
      end
      8, 9: begin
        ins = {u[20], u[10:1], u[11], u[19:12], rd, 7'h6f};
        e.target = pc + {{11{u[20]}}, u[20:1], 1'b0};
        if (r[16]) begin
          ins      = {imm[11:0], rs1, 3'b000, rd, 7'h67};
          e.target = (model_regs[rs1] + imm) & ~32'd1;
        end
        e.redirect = 1'b1;
        res  = pc + 32'd4;
        wen  = 1'b1;
        name = r[16] ? "JALR" : "JAL";
      end
      10, 11: begin
        ins = {imm[11:0], rs1, 3'b010, rd, 7'h03};
        if (r[16]) ins = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
        e.mem_valid = 1'b1;
        e.mem_we    = r[16];
        e.mem_addr  = model_regs[rs1] + imm;
        e.mem_wdata = model_regs[rs2];
        name = r[16] ? "STORE" : "LOAD";
      end
      12: begin
        ins  = {u[31:7], 7'h63};
        name = "BRANCH";
      end
      default: begin
        e.trap = TRAP_ILLEGAL;
        name   = "TRAP";
        case (u[31:16] % 7)
          0: ins = {7'b0000001, rs2, rs1, f3, rd, 7'h33};
          1: ins = {u[31:20], rs1, (f3[1:0] == 2'b00) ? 3'b001 : f3, rd, 7'h73};
          2: ins = {u[31:7], 7'h7f};
          3: ins = 32'h0000_0073;
          4: ins = 32'h0010_0073;
          5: ins = 32'h3020_0073;
          default: ins = 32'h1050_0073;
        endcase
        if (ins == 32'h0000_0073) e.trap = TRAP_ECALL;
        if (ins == 32'h0010_0073) e.trap = TRAP_EBREAK;
        if (ins == 32'h3020_0073) e.trap = TRAP_MRET;
        if (ins == 32'h1050_0073) e.trap = TRAP_WFI;
      end
    endcase
    // Model registers advance in issue order
    if (wen && rd != '0) begin
      e.wb_valid     = 1'b1;
      e.wb_rd        = rd;
      e.wb_data      = res;
      model_regs[rd] = res;
    end
    instr_valid_i = 1'b1;
    instr_i       = ins;
    pc_i          = pc;
    exp_q.push_back(e);
    name_q.push_back($sformatf("%s %h", name, ins));
  endtask

  // Any failed output assertion ends the run
  always @(negedge CLK) begin
    if (UUT.u_asserts.fail_count != 0) begin
      stop_run("A bound assertion on the DUT outputs failed");
    end
  end

  initial begin
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = `RV32_NOP;
    pc_i          = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    rst_i = 1'b0;
    push_idle("reset");
    push_idle("reset");
    // First 20 slots stay empty after reset
    for (int c = 0; c < 800; c++) begin
      @(negedge CLK);
      check_record(exp_q.pop_front(), name_q.pop_front());
      if (c >= 20 && (xorshift32() % 4) != 0) issue_random();
      else push_idle("idle");
    end
    for (int w = 0; exp_q.size() > 0; w++) begin
      if (w >= 4) stop_run("Timeout while waiting for the last result records");
      @(negedge CLK);
      instr_valid_i = 1'b0;
      check_record(exp_q.pop_front(), name_q.pop_front());
    end
    if (UUT.u_asserts.fail_count != 0) begin
      stop_run("A bound assertion on the DUT outputs failed");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb/rv32_exec_asserts.sv ====
// Output timing and exclusivity checks for the execute slice.
// Attached to every rv32_exec_top instance by the bind at the end.
`timescale 1ns/10ps
`default_nettype none

module rv32_exec_asserts (
  input wire logic               CLK,
  input wire logic               rst_i,
  input wire logic               instr_valid_i,
  input wire logic               wb_valid_o,
  input wire rv32_pkg::reg_idx_t wb_rd_o,
  input wire logic               mem_valid_o,
  input wire logic               redirect_o,
  input wire rv32_pkg::trap_t    trap_o
);
  import rv32_pkg::*;

  logic        any_out;
  int unsigned fail_count = 0;

  assign any_out = wb_valid_o || mem_valid_o || redirect_o || (trap_o != TRAP_NONE);

  // Fixed latency of two cycles from the strobe
  a_out_after_strobe: assert property (@(posedge CLK) disable iff (rst_i)
    any_out |-> $past(instr_valid_i, 2))
    else begin
      $error("Output record without a strobe two cycles earlier");
      fail_count++;
    end

  a_trap_alone: assert property (@(posedge CLK) disable iff (rst_i)
    (trap_o != TRAP_NONE) |-> !(wb_valid_o || mem_valid_o || redirect_o))
    else begin
      $error("Trap reported together with another effect");
      fail_count++;
    end

  a_no_x0_wb: assert property (@(posedge CLK) disable iff (rst_i)
    wb_valid_o |-> (wb_rd_o != '0))
    else begin
      $error("Writeback reported toward x0");
      fail_count++;
    end

endmodule

bind rv32_exec_top rv32_exec_asserts u_asserts (.*);

`default_nettype wire

// ==== verilog/rv32_exec_top.sv ====
// RV32I decode and execute slice. Fixed 2-cycle latency from strobe to
// result record, one strobe per cycle, no back-pressure.
// Loads and stores are reported only; branches and CSRs have no effect.
`timescale 1ns/10ps
`default_nettype none

module rv32_exec_top (
  input  logic               CLK,
  input  logic               rst_i,
  input  logic               instr_valid_i,
  input  rv32_pkg::instr_t   instr_i,
  input  rv32_pkg::word_t    pc_i,
  output logic               wb_valid_o,
  output rv32_pkg::reg_idx_t wb_rd_o,
  output rv32_pkg::word_t    wb_data_o,
  output logic               mem_valid_o,
  output logic               mem_we_o,
  output rv32_pkg::word_t    mem_addr_o,
  output rv32_pkg::word_t    mem_wdata_o,
  output logic               redirect_o,
  output rv32_pkg::word_t    target_o,
  output rv32_pkg::trap_t    trap_o
);
  import rv32_pkg::*;

  logic     cap_valid;
  instr_t   cap_instr;
  word_t    cap_pc;
  word_t    rdata1;
  word_t    rdata2;
  word_t    ex_result;
  word_t    ex_target;
  word_t    ex_store;
  logic     rf_wen;
  reg_idx_t rf_rd;
  word_t    rf_wdata;

  decode_if dec ();

  instr_capture u_capture (
    .CLK(CLK), .rst_i(rst_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .pc_i(pc_i), .valid_o(cap_valid), .instr_o(cap_instr), .pc_o(cap_pc)
  );

  control_unit u_ctrl (.instr_i(cap_instr), .cu(dec.producer));

  reg_file u_regs (
    .CLK(CLK), .rst_i(rst_i), .rs1_i(dec.rs1), .rs2_i(dec.rs2), .rd_i(rf_rd),
    .wen_i(rf_wen), .wdata_i(rf_wdata), .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

  exec_unit u_exec (
    .cu(dec.exec), .pc_i(cap_pc), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .result_o(ex_result), .target_o(ex_target), .store_data_o(ex_store)
  );

  result_stage u_result (
    .CLK(CLK), .rst_i(rst_i), .valid_i(cap_valid), .cu(dec.result),
    .result_i(ex_result), .target_i(ex_target), .store_data_i(ex_store),
    .rf_wen_o(rf_wen), .rf_rd_o(rf_rd), .rf_wdata_o(rf_wdata),
    .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
    .mem_valid_o(mem_valid_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_wdata_o(mem_wdata_o), .redirect_o(redirect_o), .target_o(target_o),
    .trap_o(trap_o)
  );

endmodule

`default_nettype wire

// ==== verilog/result_stage.sv ====
// Output register for one result record per slot. A trap suppresses
// every other effect, including the register file write.
`timescale 1ns/10ps
`default_nettype none

module result_stage (
  input  logic               CLK,
  input  logic               rst_i,
  input  logic               valid_i,
  decode_if.result           cu,
  input  rv32_pkg::word_t    result_i,
  input  rv32_pkg::word_t    target_i,
  input  rv32_pkg::word_t    store_data_i,
  output logic               rf_wen_o,
  output rv32_pkg::reg_idx_t rf_rd_o,
  output rv32_pkg::word_t    rf_wdata_o,
  output logic               wb_valid_o,
  output rv32_pkg::reg_idx_t wb_rd_o,
  output rv32_pkg::word_t    wb_data_o,
  output logic               mem_valid_o,
  output logic               mem_we_o,
  output rv32_pkg::word_t    mem_addr_o,
  output rv32_pkg::word_t    mem_wdata_o,
  output logic               redirect_o,
  output rv32_pkg::word_t    target_o,
  output rv32_pkg::trap_t    trap_o
);
  import rv32_pkg::*;

  logic ok;

  // Valid slot with no trap
  assign ok = valid_i && (cu.trap == TRAP_NONE);

  // Register file writes at the same edge as the output record
  assign rf_wen_o   = ok && cu.wen;
  assign rf_rd_o    = cu.rd;
  assign rf_wdata_o = result_i;

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      wb_valid_o  <= 1'b0;
      mem_valid_o <= 1'b0;
      redirect_o  <= 1'b0;
      trap_o      <= TRAP_NONE;
    end else begin
      wb_valid_o  <= ok && cu.wen && (cu.rd != '0);
      mem_valid_o <= ok && (cu.dren || cu.dwen);
      redirect_o  <= ok && cu.jump;
      trap_o      <= valid_i ? cu.trap : TRAP_NONE;
    end
  end

  // Payload qualified by the valid bits above
  always_ff @(posedge CLK) begin
    wb_rd_o     <= cu.rd;
    wb_data_o   <= result_i;
    mem_we_o    <= cu.dwen;
    mem_addr_o  <= result_i;
    mem_wdata_o <= store_data_i;
    target_o    <= target_i;
  end

endmodule

`default_nettype wire

// ==== verilog/exec_unit.sv ====
// Operand muxes, ALU, link value and jump target. Fully combinational.
// Shift amounts use the low 5 bits of operand B.
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
  decode_if.exec          cu,
  input  rv32_pkg::word_t pc_i,
  input  rv32_pkg::word_t rdata1_i,
  input  rv32_pkg::word_t rdata2_i,
  output rv32_pkg::word_t result_o,
  output rv32_pkg::word_t target_o,
  output rv32_pkg::word_t store_data_o
);
  import rv32_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_out;
  word_t link;

  assign op_a = (cu.a_sel == A_PC) ? pc_i : rdata1_i;

  always_comb begin
    case (cu.b_sel)
      B_IMM_I, B_IMM_S, B_IMM_U: op_b = cu.imm;
      B_SHAMT: op_b = word_t'(cu.imm[4:0]);
      default: op_b = rdata2_i;
    endcase
  end

  always_comb begin
    case (cu.alu_op)
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_SLL:  alu_out = op_a << op_b[4:0];
      ALU_SLT:  alu_out = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: alu_out = word_t'(op_a < op_b);
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SRL:  alu_out = op_a >> op_b[4:0];
      ALU_SRA:  alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:   alu_out = op_a | op_b;
      ALU_AND:  alu_out = op_a & op_b;
      default:  alu_out = op_a + op_b;
    endcase
  end

  assign link     = pc_i + word_t'(4);
  assign result_o = (cu.w_sel == W_LINK) ? link : alu_out;

  // JALR clears bit 0 of the sum
  assign target_o = cu.jalr_sel ? ((rdata1_i + cu.imm) & ~word_t'(1)) : (pc_i + cu.imm);

  assign store_data_o = rdata2_i;

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// 32 x 32-bit register file, two combinational reads, one write.
// x0 reads zero; a write in a cycle is seen by reads only after the edge.
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic               CLK,
  input  logic               rst_i,
  input  rv32_pkg::reg_idx_t rs1_i,
  input  rv32_pkg::reg_idx_t rs2_i,
  input  rv32_pkg::reg_idx_t rd_i,
  input  logic               wen_i,
  input  rv32_pkg::word_t    wdata_i,
  output rv32_pkg::word_t    rdata1_o,
  output rv32_pkg::word_t    rdata2_o
);
  import rv32_pkg::*;

  word_t regs [32];

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // x0 is never written, so it stays at its reset value
  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

endmodule

`default_nettype wire

// ==== verilog/control_unit.sv ====
// Combinational RV32I decoder. CSR instructions and unknown opcodes
// report ILLEGAL; FENCE decodes as a no-op. Branches produce no effect.
`timescale 1ns/10ps
`default_nettype none

module control_unit (
  input rv32_pkg::instr_t instr_i,
  decode_if.producer      cu
);
  import rv32_pkg::*;

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] sys_imm;
  logic        shift_op;
  trap_t       sys_trap;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_b;
  word_t       imm_u;
  word_t       imm_j;

  assign opcode   = opcode_t'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign funct7   = instr_i[31:25];
  assign sys_imm  = instr_i[31:20];
  assign shift_op = (funct3 == 3'b001) || (funct3 == 3'b101);

  // Sign-extended immediates by format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // U and J formats have no rs1; x0 makes LUI a plain add of zero
  assign cu.rs1 = (opcode == LUI || opcode == AUIPC || opcode == JAL) ?
                  reg_idx_t'(0) : instr_i[19:15];
  assign cu.rs2 = instr_i[24:20];
  assign cu.rd  = instr_i[11:7];

  // Privileged SYSTEM encodings with funct3 of zero
  always_comb begin
    sys_trap = TRAP_ILLEGAL;
    if (funct3 == 3'b000) begin
      case (sys_imm)
        12'h000: sys_trap = TRAP_ECALL;
        12'h001: sys_trap = TRAP_EBREAK;
        12'h302: sys_trap = TRAP_MRET;
        12'h105: sys_trap = TRAP_WFI;
        default: sys_trap = TRAP_ILLEGAL;
      endcase
    end
  end

  always_comb begin
    cu.imm      = imm_i;
    cu.a_sel    = A_RS1;
    cu.b_sel    = B_RS2;
    cu.w_sel    = W_ALU;
    cu.wen      = 1'b0;
    cu.dren     = 1'b0;
    cu.dwen     = 1'b0;
    cu.jump     = 1'b0;
    cu.jalr_sel = 1'b0;
    cu.trap     = TRAP_NONE;
    case (opcode)
      LUI: begin
        cu.imm   = imm_u;
        cu.b_sel = B_IMM_U;
        cu.wen   = 1'b1;
      end
      AUIPC: begin
        cu.imm   = imm_u;
        cu.a_sel = A_PC;
        cu.b_sel = B_IMM_U;
        cu.wen   = 1'b1;
      end
      JAL: begin
        cu.imm   = imm_j;
        cu.w_sel = W_LINK;
        cu.wen   = 1'b1;
        cu.jump  = 1'b1;
      end
      JALR: begin
        cu.w_sel    = W_LINK;
        cu.wen      = 1'b1;
        cu.jump     = 1'b1;
        cu.jalr_sel = 1'b1;
      end
      BRANCH: cu.imm = imm_b;
      // Load reports its address only
      LOAD: begin
        cu.b_sel = B_IMM_I;
        cu.dren  = 1'b1;
      end
      STORE: begin
        cu.imm   = imm_s;
        cu.b_sel = B_IMM_S;
        cu.dwen  = 1'b1;
      end
      IMMED: begin
        cu.b_sel = shift_op ? B_SHAMT : B_IMM_I;
        cu.wen   = 1'b1;
      end
      REGREG: begin
        cu.wen = 1'b1;
        // funct7 bit 0 marks the unsupported M extension
        if (funct7[0]) cu.trap = TRAP_ILLEGAL;
      end
      MISCMEM: cu.trap = TRAP_NONE;
      SYSTEM:  cu.trap = sys_trap;
      default: cu.trap = TRAP_ILLEGAL;
    endcase
  end

  // funct3 picks the operation; bit 30 splits SUB and SRA
  always_comb begin
    cu.alu_op = ALU_ADD;
    if (opcode == IMMED || opcode == REGREG) begin
      case (funct3)
        3'b000:  cu.alu_op = (opcode == REGREG && instr_i[30]) ? ALU_SUB : ALU_ADD;
        3'b001:  cu.alu_op = ALU_SLL;
        3'b010:  cu.alu_op = ALU_SLT;
        3'b011:  cu.alu_op = ALU_SLTU;
        3'b100:  cu.alu_op = ALU_XOR;
        3'b101:  cu.alu_op = instr_i[30] ? ALU_SRA : ALU_SRL;
        3'b110:  cu.alu_op = ALU_OR;
        default: cu.alu_op = ALU_AND;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/instr_capture.sv ====
// Input register for the instruction strobe. No handshake; a strobe
// is accepted on every clock. Empty slots hold a NOP.
`timescale 1ns/10ps
`include "rv32_macros.svh"
`default_nettype none

module instr_capture (
  input  logic           CLK,
  input  logic           rst_i,
  input  logic           instr_valid_i,
  input  rv32_pkg::instr_t instr_i,
  input  rv32_pkg::word_t  pc_i,
  output logic           valid_o,
  output rv32_pkg::instr_t instr_o,
  output rv32_pkg::word_t  pc_o
);
  import rv32_pkg::*;

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      instr_o <= `RV32_NOP;
      pc_o    <= `RV32_RESET_PC;
    end else begin
      valid_o <= instr_valid_i;
      // NOP decodes to no effect if the slot is read while empty
      instr_o <= instr_valid_i ? instr_i : instr_t'(`RV32_NOP);
      pc_o    <= pc_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/decode_if.sv ====
// Decoded control fields from the control unit to the execute and
// result stages. All fields are combinational from the captured slot.
`timescale 1ns/10ps
`default_nettype none

interface decode_if;
  import rv32_pkg::*;

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  alu_op_t  alu_op;
  a_sel_t   a_sel;
  b_sel_t   b_sel;
  w_sel_t   w_sel;
  logic     wen;
  logic     dren;
  logic     dwen;
  logic     jump;
  logic     jalr_sel;
  trap_t    trap;

  modport producer (
    output rs1, rs2, rd, imm, alu_op, a_sel, b_sel, w_sel,
    output wen, dren, dwen, jump, jalr_sel, trap
  );

  // Operand and ALU controls
  modport exec (input imm, alu_op, a_sel, b_sel, w_sel, jalr_sel);

  // Effects qualified in the output register
  modport result (input rd, wen, dren, dwen, jump, trap);

endinterface

`default_nettype wire

// ==== verilog/rv32_pkg.sv ====
// Types and decode codes for the RV32I execute slice.
// Opcode values are the standard RV32I major opcodes.
`include "rv32_macros.svh"
`default_nettype none

package rv32_pkg;

  typedef logic [`RV32_XLEN-1:0] word_t;
  typedef logic [`RV32_XLEN-1:0] instr_t;
  typedef logic [`RV32_REG_AW-1:0] reg_idx_t;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef enum logic [1:0] {A_RS1, A_PC} a_sel_t;

  // Five sources need a third bit
  typedef enum logic [2:0] {B_RS2, B_IMM_I, B_IMM_S, B_IMM_U, B_SHAMT} b_sel_t;

  typedef enum logic [1:0] {W_ALU, W_LINK} w_sel_t;

  typedef enum logic [2:0] {
    TRAP_NONE,
    TRAP_ILLEGAL,
    TRAP_ECALL,
    TRAP_EBREAK,
    TRAP_MRET,
    TRAP_WFI
  } trap_t;

endpackage

`default_nettype wire

// ==== verilog/rv32_macros.svh ====
// Width and encoding constants shared by the RV32I execute slice.
// The reset PC only seeds the capture register; no fetch exists here.
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// Data word and register index widths
`define RV32_XLEN 32
`define RV32_REG_AW 5

// PC held in the capture stage after reset
`define RV32_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0 fills an empty slot
`define RV32_NOP 32'h0000_0013

`endif
